//--- logic/mem_settings.svh
// Memory-system widths and sizes; include in any file that sizes a bus, a line or a cache
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Byte address width, as seen by the core
`define ADDR_WIDTH 26

// One machine word
`define DATA_WIDTH 32

// Words per line, also the refill burst length
`define LINE_WORDS 4

// Lines in each cache
`define CACHE_LINES 16

// ID width on the external port
`define AXI_ID_WIDTH 4

`endif

//--- logic/axi_pkg.sv
// External bus types; imported by every block that drives or samples the AXI-style port
`default_nettype none
`include "mem_settings.svh"

package axi_pkg;

	// Transaction ID
	// 0 for the instruction cache, 1 for the data cache
	typedef logic [`AXI_ID_WIDTH-1:0] axi_id_t;

	// Burst length minus one
	typedef logic [3:0] axi_len_t;

	// Byte address and data word
	typedef logic [`ADDR_WIDTH-1:0] axi_addr_t;
	typedef logic [`DATA_WIDTH-1:0] axi_data_t;

	// Only the data cache writes
	localparam axi_id_t DCACHE_ID = axi_id_t'(1);

endpackage

`default_nettype wire

//--- logic/cache_pkg.sv
// Cache-side types and address split; imported by both caches
`default_nettype none
`include "mem_settings.svh"

package cache_pkg;

	// Address split: tag | index | word offset | byte
	localparam int BYTE_BITS   = $clog2(`DATA_WIDTH / 8);
	localparam int OFFSET_BITS = $clog2(`LINE_WORDS);
	localparam int INDEX_BITS  = $clog2(`CACHE_LINES);
	localparam int INDEX_LSB   = BYTE_BITS + OFFSET_BITS;
	localparam int TAG_LSB     = INDEX_LSB + INDEX_BITS;
	localparam int TAG_BITS    = `ADDR_WIDTH - TAG_LSB;

	// Load or store
	typedef enum logic {READ, WRITE} mem_action_t;

	typedef logic [TAG_BITS-1:0]    cache_tag_t;
	typedef logic [INDEX_BITS-1:0]  cache_index_t;
	typedef logic [OFFSET_BITS-1:0] cache_offset_t;

	// Miss and write sequencing
	typedef enum logic [1:0] {STATE_IDLE, STATE_REQUEST, STATE_REFILL, STATE_WRITE} line_state_t;

endpackage

`default_nettype wire

//--- logic/i_cache.sv
// Direct-mapped read-only instruction cache; serves fetches and refills a missing line by burst
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module i_cache (
	input  logic               clk,
	input  logic               i_arst_n,
	// Fetch port
	input  logic               i_if_req,
	input  axi_pkg::axi_addr_t i_if_addr,
	output logic               o_if_valid,
	output axi_pkg::axi_data_t o_if_data,
	// Refill read master
	output logic               o_arvalid,
	output axi_pkg::axi_addr_t o_araddr,
	input  logic               i_arready,
	input  logic               i_rvalid,
	input  logic               i_rlast,
	input  axi_pkg::axi_data_t i_rdata
);
	import axi_pkg::*;
	import cache_pkg::*;

	// Line storage
	logic [`CACHE_LINES-1:0] valid_q;
	cache_tag_t              tag_q  [`CACHE_LINES];
	axi_data_t               data_q [`CACHE_LINES][`LINE_WORDS];

	// Miss tracking
	line_state_t   state_q;
	cache_offset_t beat_q;
	axi_addr_t     miss_addr_q;

	// Live request fields
	cache_tag_t    req_tag;
	cache_index_t  req_index;
	cache_offset_t req_offset;
	logic          accept;
	logic          hit;

	// Fields of the line under refill
	cache_tag_t    fill_tag;
	cache_index_t  fill_index;
	cache_offset_t fill_offset;

	assign req_tag     = cache_tag_t'(i_if_addr >> TAG_LSB);
	assign req_index   = cache_index_t'(i_if_addr >> INDEX_LSB);
	assign req_offset  = cache_offset_t'(i_if_addr >> BYTE_BITS);
	assign fill_tag    = cache_tag_t'(miss_addr_q >> TAG_LSB);
	assign fill_index  = cache_index_t'(miss_addr_q >> INDEX_LSB);
	assign fill_offset = cache_offset_t'(miss_addr_q >> BYTE_BITS);

	// Held request is ignored in its own answer cycle
	assign accept = i_if_req && !o_if_valid && (state_q == STATE_IDLE);
	assign hit    = valid_q[req_index] && (tag_q[req_index] == req_tag);

	// Burst always starts at the line base
	assign o_arvalid = (state_q == STATE_REQUEST);
	assign o_araddr  = (miss_addr_q >> INDEX_LSB) << INDEX_LSB;

	// ======================================================================
	// Control
	// ======================================================================
	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			state_q    <= STATE_IDLE;
			valid_q    <= '0;
			beat_q     <= '0;
			o_if_valid <= 1'b0;
		end
		else
		begin
			// Answer is a single-cycle pulse
			o_if_valid <= 1'b0;
			case (state_q)
				STATE_IDLE:
				begin
					if (accept && hit)
						o_if_valid <= 1'b1;
					else if (accept)
						state_q <= STATE_REQUEST;
				end
				STATE_REQUEST:
				begin
					// Address taken, beats follow
					if (i_arready)
					begin
						state_q <= STATE_REFILL;
						beat_q  <= '0;
					end
				end
				STATE_REFILL:
				begin
					if (i_rvalid)
					begin
						beat_q <= beat_q + 1'b1;
						// Line complete, answer next cycle
						if (i_rlast)
						begin
							valid_q[fill_index] <= 1'b1;
							o_if_valid          <= 1'b1;
							state_q             <= STATE_IDLE;
						end
					end
				end
				default: state_q <= STATE_IDLE;
			endcase
		end
	end

	// ======================================================================
	// Arrays and payload
	// ======================================================================
	always_ff @(posedge clk)
	begin
		if (accept)
			miss_addr_q <= i_if_addr;
		if (accept && hit)
			o_if_data <= data_q[req_index][req_offset];
		if ((state_q == STATE_REFILL) && i_rvalid)
		begin
			data_q[fill_index][beat_q] <= i_rdata;
			// Requested word picked off as it streams past
			if (beat_q == fill_offset)
				o_if_data <= i_rdata;
			if (i_rlast)
				tag_q[fill_index] <= fill_tag;
		end
	end

endmodule

`default_nettype wire

//--- logic/d_cache.sv
// Direct-mapped write-through data cache; serves loads and stores for the memory stage
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module d_cache (
	input  logic                  clk,
	input  logic                  i_arst_n,
	// Load/store port
	input  logic                  i_dc_req,
	input  cache_pkg::mem_action_t i_dc_action,
	input  axi_pkg::axi_addr_t    i_dc_addr,
	input  axi_pkg::axi_data_t    i_dc_wdata,
	output logic                  o_dc_done,
	output axi_pkg::axi_data_t    o_dc_rdata,
	// Refill read master
	output logic                  o_arvalid,
	output axi_pkg::axi_addr_t    o_araddr,
	input  logic                  i_arready,
	input  logic                  i_rvalid,
	input  logic                  i_rlast,
	input  axi_pkg::axi_data_t    i_rdata,
	// Single-beat write master
	output logic                  o_awvalid,
	output axi_pkg::axi_addr_t    o_awaddr,
	input  logic                  i_awready,
	output logic                  o_wvalid,
	output axi_pkg::axi_data_t    o_wdata,
	input  logic                  i_wready,
	input  logic                  i_bvalid
);
	import axi_pkg::*;
	import cache_pkg::*;

	// Line storage
	logic [`CACHE_LINES-1:0] valid_q;
	cache_tag_t              tag_q  [`CACHE_LINES];
	axi_data_t               data_q [`CACHE_LINES][`LINE_WORDS];

	// Miss or write in flight
	line_state_t   state_q;
	cache_offset_t beat_q;
	axi_addr_t     req_addr_q;

	// Live request fields
	cache_tag_t    req_tag;
	cache_index_t  req_index;
	cache_offset_t req_offset;
	logic          accept;
	logic          hit;

	// Fields of the latched request
	cache_tag_t    fill_tag;
	cache_index_t  fill_index;
	cache_offset_t fill_offset;

	assign req_tag     = cache_tag_t'(i_dc_addr >> TAG_LSB);
	assign req_index   = cache_index_t'(i_dc_addr >> INDEX_LSB);
	assign req_offset  = cache_offset_t'(i_dc_addr >> BYTE_BITS);
	assign fill_tag    = cache_tag_t'(req_addr_q >> TAG_LSB);
	assign fill_index  = cache_index_t'(req_addr_q >> INDEX_LSB);
	assign fill_offset = cache_offset_t'(req_addr_q >> BYTE_BITS);

	assign accept = i_dc_req && !o_dc_done && (state_q == STATE_IDLE);
	assign hit    = valid_q[req_index] && (tag_q[req_index] == req_tag);

	assign o_arvalid = (state_q == STATE_REQUEST);
	assign o_araddr  = (req_addr_q >> INDEX_LSB) << INDEX_LSB;
	// Store goes out at the word address as given
	assign o_awaddr  = req_addr_q;

	// ======================================================================
	// Control
	// ======================================================================
	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			state_q   <= STATE_IDLE;
			valid_q   <= '0;
			beat_q    <= '0;
			o_dc_done <= 1'b0;
			o_awvalid <= 1'b0;
			o_wvalid  <= 1'b0;
		end
		else
		begin
			o_dc_done <= 1'b0;
			case (state_q)
				STATE_IDLE:
				begin
					// Stores always go to memory, hit or miss
					if (accept && (i_dc_action == WRITE))
					begin
						state_q   <= STATE_WRITE;
						o_awvalid <= 1'b1;
						o_wvalid  <= 1'b1;
					end
					else if (accept && hit)
						o_dc_done <= 1'b1;
					else if (accept)
						state_q <= STATE_REQUEST;
				end
				STATE_REQUEST:
				begin
					if (i_arready)
					begin
						state_q <= STATE_REFILL;
						beat_q  <= '0;
					end
				end
				STATE_REFILL:
				begin
					if (i_rvalid)
					begin
						beat_q <= beat_q + 1'b1;
						if (i_rlast)
						begin
							valid_q[fill_index] <= 1'b1;
							o_dc_done           <= 1'b1;
							state_q             <= STATE_IDLE;
						end
					end
				end
				STATE_WRITE:
				begin
					// Address and data channels retire on their own
					if (i_awready)
						o_awvalid <= 1'b0;
					if (i_wready)
						o_wvalid <= 1'b0;
					// Response ends the store
					if (i_bvalid)
					begin
						o_dc_done <= 1'b1;
						state_q   <= STATE_IDLE;
					end
				end
				default: state_q <= STATE_IDLE;
			endcase
		end
	end

	// ======================================================================
	// Arrays and payload
	// ======================================================================
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req_addr_q <= i_dc_addr;
			o_wdata    <= i_dc_wdata;
		end
		if (accept && hit && (i_dc_action == READ))
			o_dc_rdata <= data_q[req_index][req_offset];
		// Write hit keeps the cached copy current; no allocate on a miss
		if (accept && hit && (i_dc_action == WRITE))
			data_q[req_index][req_offset] <= i_dc_wdata;
		if ((state_q == STATE_REFILL) && i_rvalid)
		begin
			data_q[fill_index][beat_q] <= i_rdata;
			if (beat_q == fill_offset)
				o_dc_rdata <= i_rdata;
			if (i_rlast)
				tag_q[fill_index] <= fill_tag;
		end
	end

endmodule

`default_nettype wire

//--- logic/memory_arbiter.sv
// Round-robin share of the external read channel among the caches, plus the data-cache write path
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module memory_arbiter #(
	parameter int READ_MASTERS = 2
) (
	input  logic                    clk,
	input  logic                    i_arst_n,
	// Cache read masters, indexed by ID
	input  logic [READ_MASTERS-1:0] i_m_arvalid,
	input  axi_pkg::axi_addr_t      i_m_araddr [READ_MASTERS],
	output logic [READ_MASTERS-1:0] o_m_arready,
	output logic [READ_MASTERS-1:0] o_m_rvalid,
	output logic [READ_MASTERS-1:0] o_m_rlast,
	output axi_pkg::axi_data_t      o_m_rdata  [READ_MASTERS],
	// Data cache write master
	input  logic                    i_m_awvalid,
	input  axi_pkg::axi_addr_t      i_m_awaddr,
	output logic                    o_m_awready,
	input  logic                    i_m_wvalid,
	input  axi_pkg::axi_data_t      i_m_wdata,
	output logic                    o_m_wready,
	output logic                    o_m_bvalid,
	// External read channel
	output logic                    o_arvalid,
	output axi_pkg::axi_id_t        o_arid,
	output axi_pkg::axi_len_t       o_arlen,
	output axi_pkg::axi_addr_t      o_araddr,
	input  logic                    i_arready,
	output logic                    o_rready,
	input  logic                    i_rvalid,
	input  logic                    i_rlast,
	input  axi_pkg::axi_id_t        i_rid,
	input  axi_pkg::axi_data_t      i_rdata,
	// External write channel
	output logic                    o_awvalid,
	output axi_pkg::axi_id_t        o_awid,
	output axi_pkg::axi_addr_t      o_awaddr,
	input  logic                    i_awready,
	output logic                    o_wvalid,
	output logic                    o_wlast,
	output axi_pkg::axi_data_t      o_wdata,
	input  logic                    i_wready,
	output logic                    o_bready,
	input  logic                    i_bvalid
);
	import axi_pkg::*;

	localparam int IDX_W = (READ_MASTERS > 1) ? $clog2(READ_MASTERS) : 1;

	// First master to look at next time
	logic [IDX_W-1:0] rr_ptr_q;
	logic [IDX_W-1:0] grant_q;
	logic [IDX_W-1:0] pick;
	logic [IDX_W-1:0] grant;
	// Burst accepted, waiting for RLAST
	logic             busy_q;
	// Address on the bus, not yet taken
	logic             hold_q;

	// Nearest requester from the pointer wins
	always_comb
	begin
		pick = rr_ptr_q;
		for (int i = READ_MASTERS - 1; i >= 0; i--)
		begin
			if (i_m_arvalid[(int'(rr_ptr_q) + i) % READ_MASTERS])
				pick = IDX_W'((int'(rr_ptr_q) + i) % READ_MASTERS);
		end
	end

	// Frozen while an address waits or a burst runs
	assign grant = (busy_q || hold_q) ? grant_q : pick;

	assign o_arvalid = !busy_q && i_m_arvalid[grant];
	assign o_araddr  = i_m_araddr[grant];
	assign o_arid    = axi_id_t'(grant);
	assign o_arlen   = axi_len_t'(`LINE_WORDS - 1);
	assign o_rready  = 1'b1;

	// Ready to the granted master only, data steered back by ID
	always_comb
	begin
		for (int m = 0; m < READ_MASTERS; m++)
		begin
			o_m_arready[m] = !busy_q && i_arready && (grant == IDX_W'(m));
			o_m_rvalid[m]  = i_rvalid && (i_rid == axi_id_t'(m));
			o_m_rlast[m]   = i_rlast && (i_rid == axi_id_t'(m));
			o_m_rdata[m]   = i_rdata;
		end
	end

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			rr_ptr_q <= '0;
			grant_q  <= '0;
			busy_q   <= 1'b0;
			hold_q   <= 1'b0;
		end
		else
		begin
			hold_q <= o_arvalid && !i_arready;
			if (o_arvalid)
				grant_q <= grant;
			// Handshake: lock the bus and rotate priority
			if (o_arvalid && i_arready)
			begin
				busy_q   <= 1'b1;
				rr_ptr_q <= (grant == IDX_W'(READ_MASTERS - 1)) ? '0 : grant + 1'b1;
			end
			else if (i_rvalid && i_rlast)
				busy_q <= 1'b0;
		end
	end

	// ======================================================================
	// Write path, single beat tagged as the data cache
	// ======================================================================
	assign o_awvalid   = i_m_awvalid;
	assign o_awid      = DCACHE_ID;
	assign o_awaddr    = i_m_awaddr;
	assign o_m_awready = i_awready;
	assign o_wvalid    = i_m_wvalid;
	assign o_wlast     = 1'b1;
	assign o_wdata     = i_m_wdata;
	assign o_m_wready  = i_wready;
	assign o_bready    = 1'b1;
	assign o_m_bvalid  = i_bvalid;

endmodule

`default_nettype wire

//--- logic/mem_subsys_top.sv
// Memory subsystem top; joins both caches to one external AXI-style port through the arbiter
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
	input  logic                   clk,
	input  logic                   i_arst_n,
	// Fetch port
	input  logic                   i_if_req,
	input  axi_pkg::axi_addr_t     i_if_addr,
	output logic                   o_if_valid,
	output axi_pkg::axi_data_t     o_if_data,
	// Load/store port
	input  logic                   i_dc_req,
	input  cache_pkg::mem_action_t i_dc_action,
	input  axi_pkg::axi_addr_t     i_dc_addr,
	input  axi_pkg::axi_data_t     i_dc_wdata,
	output logic                   o_dc_done,
	output axi_pkg::axi_data_t     o_dc_rdata,
	// External port
	output logic                   o_arvalid,
	output axi_pkg::axi_id_t       o_arid,
	output axi_pkg::axi_len_t      o_arlen,
	output axi_pkg::axi_addr_t     o_araddr,
	input  logic                   i_arready,
	output logic                   o_rready,
	input  logic                   i_rvalid,
	input  logic                   i_rlast,
	input  axi_pkg::axi_id_t       i_rid,
	input  axi_pkg::axi_data_t     i_rdata,
	output logic                   o_awvalid,
	output axi_pkg::axi_id_t       o_awid,
	output axi_pkg::axi_addr_t     o_awaddr,
	input  logic                   i_awready,
	output logic                   o_wvalid,
	output logic                   o_wlast,
	output axi_pkg::axi_data_t     o_wdata,
	input  logic                   i_wready,
	output logic                   o_bready,
	input  logic                   i_bvalid
);
	import axi_pkg::*;

	// Master 0 fetches, master 1 loads
	localparam int READ_MASTERS = 2;

	logic [READ_MASTERS-1:0] m_arvalid;
	logic [READ_MASTERS-1:0] m_arready;
	logic [READ_MASTERS-1:0] m_rvalid;
	logic [READ_MASTERS-1:0] m_rlast;
	axi_addr_t               m_araddr [READ_MASTERS];
	axi_data_t               m_rdata  [READ_MASTERS];

	// Store path from the data cache
	logic      dc_awvalid;
	logic      dc_awready;
	logic      dc_wvalid;
	logic      dc_wready;
	logic      dc_bvalid;
	axi_addr_t dc_awaddr;
	axi_data_t dc_wdata;

	i_cache u_i_cache (
		.*,
		.o_arvalid (m_arvalid[0]),
		.o_araddr  (m_araddr[0]),
		.i_arready (m_arready[0]),
		.i_rvalid  (m_rvalid[0]),
		.i_rlast   (m_rlast[0]),
		.i_rdata   (m_rdata[0])
	);

	d_cache u_d_cache (
		.*,
		.o_arvalid (m_arvalid[1]),
		.o_araddr  (m_araddr[1]),
		.i_arready (m_arready[1]),
		.i_rvalid  (m_rvalid[1]),
		.i_rlast   (m_rlast[1]),
		.i_rdata   (m_rdata[1]),
		.o_awvalid (dc_awvalid),
		.o_awaddr  (dc_awaddr),
		.i_awready (dc_awready),
		.o_wvalid  (dc_wvalid),
		.o_wdata   (dc_wdata),
		.i_wready  (dc_wready),
		.i_bvalid  (dc_bvalid)
	);

	memory_arbiter #(.READ_MASTERS(READ_MASTERS)) u_memory_arbiter (
		.*,
		.i_m_arvalid (m_arvalid),
		.i_m_araddr  (m_araddr),
		.o_m_arready (m_arready),
		.o_m_rvalid  (m_rvalid),
		.o_m_rlast   (m_rlast),
		.o_m_rdata   (m_rdata),
		.i_m_awvalid (dc_awvalid),
		.i_m_awaddr  (dc_awaddr),
		.o_m_awready (dc_awready),
		.i_m_wvalid  (dc_wvalid),
		.i_m_wdata   (dc_wdata),
		.o_m_wready  (dc_wready),
		.o_m_bvalid  (dc_bvalid)
	);

endmodule

`default_nettype wire

//--- sim/mem_subsys_chk.sv
// Protocol and reset assertions on the memory subsystem; bound into mem_subsys_top by the testbench
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_chk (
	input logic               clk,
	input logic               i_arst_n,
	input logic               o_arvalid,
	input axi_pkg::axi_addr_t o_araddr,
	input logic               i_arready,
	input logic               i_rvalid,
	input logic               i_rlast,
	input logic               o_awvalid,
	input logic               i_awready,
	input logic               o_if_valid,
	input logic               o_dc_done
);
	// Count of failed assertions
	int assert_fails = 0;

	// Burst open from address handshake to last beat
	logic burst_open;

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			burst_open <= 1'b0;
		else if (o_arvalid && i_arready)
			burst_open <= 1'b1;
		else if (i_rvalid && i_rlast)
			burst_open <= 1'b0;
	end

	// ======================================================================
	// Read and write address channels
	// ======================================================================
	ar_held: assert property (@(posedge clk) disable iff (!i_arst_n)
		(o_arvalid && !i_arready) |=> (o_arvalid && $stable(o_araddr)))
	else
	begin
		$error("ARVALID or ARADDR changed before ARREADY");
		assert_fails++;
	end

	aw_held: assert property (@(posedge clk) disable iff (!i_arst_n)
		(o_awvalid && !i_awready) |=> o_awvalid)
	else
	begin
		$error("AWVALID dropped before AWREADY");
		assert_fails++;
	end

	// One burst at a time on the shared channel
	ar_single: assert property (@(posedge clk) disable iff (!i_arst_n)
		burst_open |-> !o_arvalid)
	else
	begin
		$error("second read address issued before RLAST");
		assert_fails++;
	end

	// Quiet CPU side while in reset
	reset_quiet: assert property (@(posedge clk)
		!i_arst_n |-> (!o_if_valid && !o_dc_done))
	else
	begin
		$error("CPU answer pulse raised during reset");
		assert_fails++;
	end

endmodule

`default_nettype wire

//--- sim/mem_subsys_tb.sv
// Memory subsystem testbench; replays the operation trace against a stalling AXI memory model
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module mem_subsys_tb;
	import axi_pkg::*;
	import cache_pkg::*;

	localparam string TRACE_PATH = "sim/mem_trace.txt";
	localparam int MAX_OPS = 64;
	// Watchdog budget per trace line
	localparam int CYCLES_PER_OP = 200;

	integer seed = 32'he8001a8e;

	// DUT ports
	logic        clk;
	logic        i_arst_n;
	logic        i_if_req;
	axi_addr_t   i_if_addr;
	logic        o_if_valid;
	axi_data_t   o_if_data;
	logic        i_dc_req;
	mem_action_t i_dc_action;
	axi_addr_t   i_dc_addr;
	axi_data_t   i_dc_wdata;
	logic        o_dc_done;
	axi_data_t   o_dc_rdata;
	logic        o_arvalid;
	axi_id_t     o_arid;
	axi_len_t    o_arlen;
	axi_addr_t   o_araddr;
	logic        i_arready;
	logic        o_rready;
	logic        i_rvalid;
	logic        i_rlast;
	axi_id_t     i_rid;
	axi_data_t   i_rdata;
	logic        o_awvalid;
	axi_id_t     o_awid;
	axi_addr_t   o_awaddr;
	logic        i_awready;
	logic        o_wvalid;
	logic        o_wlast;
	axi_data_t   o_wdata;
	logic        i_wready;
	logic        o_bready;
	logic        i_bvalid;

	// Trace contents
	logic [7:0] t_port  [MAX_OPS];
	logic [7:0] t_op    [MAX_OPS];
	axi_addr_t  t_addr  [MAX_OPS];
	axi_data_t  t_wdata [MAX_OPS];
	axi_data_t  t_exp   [MAX_OPS];
	int         n_ops;
	logic       trace_loaded;
	int         errors;

	// Memory model state and words overwritten by completed stores
	axi_data_t written [int];
	logic      rd_pending;
	axi_addr_t rd_addr;
	axi_id_t   rd_id;
	int        rd_len;
	int        rd_beat;
	int        rd_wait;
	logic      aw_seen;
	logic      w_seen;
	int        b_wait;
	axi_addr_t wr_addr;
	axi_data_t wr_data;
	int        aw_count;
	int        w_count;
	// Read bursts taken per ID and the last address of each
	int        ar_count [2];
	axi_addr_t ar_line  [2];

	mem_subsys_top dut (.*);

	bind mem_subsys_top mem_subsys_chk u_chk (.*);

	always #2 clk = ~clk;

	// Untouched words read as A5 over the word address
	function automatic axi_data_t mem_word(input axi_addr_t addr);
		if (written.exists(int'(addr)))
			return written[int'(addr)];
		return {8'hA5, addr[`ADDR_WIDTH-1:2]};
	endfunction

	// Refill bursts start at the line base
	function automatic axi_addr_t line_base(input axi_addr_t addr);
		return addr & ~axi_addr_t'(`LINE_WORDS * 4 - 1);
	endfunction

	// ======================================================================
	// AXI memory model with all decisions on the falling edge
	// ======================================================================
	always @(negedge clk)
	begin
		i_rvalid = 1'b0;
		i_rlast  = 1'b0;
		i_bvalid = 1'b0;
		// Beats of the burst in flight with random gaps
		if (rd_pending)
		begin
			if (rd_wait > 0)
				rd_wait--;
			else if (($random(seed) & 7) != 0)
			begin
				i_rvalid = 1'b1;
				i_rid    = rd_id;
				i_rdata  = mem_word(rd_addr + axi_addr_t'(4 * rd_beat));
				i_rlast  = (rd_beat == rd_len);
				if (o_rready !== 1'b1)
				begin
					$display("FAIL t=%0t o_rready got %b expected 1", $time, o_rready);
					errors++;
				end
				if (i_rlast)
					rd_pending = 1'b0;
				rd_beat++;
			end
		end
		// Store lands in memory with its response
		if (aw_seen && w_seen)
		begin
			if (b_wait > 0)
				b_wait--;
			else
			begin
				i_bvalid = 1'b1;
				if (o_bready !== 1'b1)
				begin
					$display("FAIL t=%0t o_bready got %b expected 1", $time, o_bready);
					errors++;
				end
				written[int'(wr_addr)] = wr_data;
				aw_seen = 1'b0;
				w_seen  = 1'b0;
			end
		end
		i_arready = ($random(seed) & 3) != 0;
		i_awready = ($random(seed) & 3) != 0;
		i_wready  = ($random(seed) & 3) != 0;
		// Handshakes that the next rising edge completes
		if (o_arvalid && i_arready)
		begin
			if (o_arlen != axi_len_t'(`LINE_WORDS - 1))
			begin
				$display("FAIL t=%0t o_arlen got %0d expected %0d", $time, o_arlen,
					`LINE_WORDS - 1);
				errors++;
			end
			if (o_arid > axi_id_t'(1))
			begin
				$display("FAIL t=%0t o_arid got %0d expected 0 or 1", $time, o_arid);
				errors++;
			end
			else
			begin
				ar_count[o_arid[0]]++;
				ar_line[o_arid[0]] = o_araddr;
			end
			rd_pending = 1'b1;
			rd_addr    = o_araddr;
			rd_id      = o_arid;
			rd_len     = int'(o_arlen);
			rd_beat    = 0;
			rd_wait    = $random(seed) & 7;
		end
		if (o_awvalid && i_awready)
		begin
			if (o_awid != axi_id_t'(1))
			begin
				$display("FAIL t=%0t o_awid got %0d expected 1", $time, o_awid);
				errors++;
			end
			aw_seen = 1'b1;
			wr_addr = o_awaddr;
			b_wait  = $random(seed) & 3;
			aw_count++;
		end
		if (o_wvalid && i_wready)
		begin
			if (o_wlast !== 1'b1)
			begin
				$display("FAIL t=%0t o_wlast got %b expected 1", $time, o_wlast);
				errors++;
			end
			w_seen  = 1'b1;
			wr_data = o_wdata;
			w_count++;
		end
	end

	// ======================================================================
	// Trace reader and CPU-side drivers
	// ======================================================================
	task automatic load_trace();
		int         fd;
		int         n;
		string      line;
		logic [7:0] port_c;
		logic [7:0] op_c;
		axi_data_t  a;
		axi_data_t  w;
		axi_data_t  e;
		fd = $fopen(TRACE_PATH, "r");
		if (fd == 0)
		begin
			$display("Could not open the trace file %s", TRACE_PATH);
			errors++;
		end
		else
		begin
			while (!$feof(fd) && (n_ops < MAX_OPS))
			begin
				line = "";
				n = $fgets(line, fd);
				// Skip column notes and blank lines
				if ((n > 0) && (line.getc(0) != "#"))
				begin
					if ($sscanf(line, "%s %s %h %h %h", port_c, op_c, a, w, e) == 5)
					begin
						t_port[n_ops]  = port_c;
						t_op[n_ops]    = op_c;
						t_addr[n_ops]  = axi_addr_t'(a);
						t_wdata[n_ops] = w;
						t_exp[n_ops]   = e;
						n_ops++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Hold the fetch until the answer pulse and leave one idle cycle
	task automatic fetch(input axi_addr_t addr, output axi_data_t data, output int cycles);
		i_if_req  = 1'b1;
		i_if_addr = addr;
		cycles    = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (!o_if_valid);
		data     = o_if_data;
		i_if_req = 1'b0;
		@(negedge clk);
	endtask

	task automatic access(input mem_action_t action, input axi_addr_t addr,
		input axi_data_t wdata, output axi_data_t data, output int cycles);
		i_dc_req    = 1'b1;
		i_dc_action = action;
		i_dc_addr   = addr;
		i_dc_wdata  = wdata;
		cycles      = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (!o_dc_done);
		data     = o_dc_rdata;
		i_dc_req = 1'b0;
		@(negedge clk);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic run_op(input int k, output int step);
		axi_data_t got;
		axi_data_t got_d;
		int        cyc;
		int        cyc_d;
		int        aw_before;
		int        w_before;
		int        ar0_before;
		int        ar1_before;
		step       = 1;
		aw_before  = aw_count;
		w_before   = w_count;
		ar0_before = ar_count[0];
		ar1_before = ar_count[1];
		if ((t_port[k] == "I") && (t_op[k] == "P") && (k + 1 < n_ops))
		begin
			// Both caches miss together and share the read channel
			fork
				fetch(t_addr[k], got, cyc);
				access(READ, t_addr[k+1], '0, got_d, cyc_d);
			join
			check_value("o_if_data", got, t_exp[k]);
			check_value("o_dc_rdata", got_d, t_exp[k+1]);
			// Fetch refill goes out as ID 0, load refill as ID 1
			check_count("o_arid 0 bursts", ar_count[0] - ar0_before, 1);
			check_count("o_arid 1 bursts", ar_count[1] - ar1_before, 1);
			check_value("o_araddr under o_arid 0", 32'(ar_line[0]),
				32'(line_base(t_addr[k])));
			check_value("o_araddr under o_arid 1", 32'(ar_line[1]),
				32'(line_base(t_addr[k+1])));
			step = 2;
		end
		else if (t_port[k] == "I")
		begin
			fetch(t_addr[k], got, cyc);
			check_value("o_if_data", got, t_exp[k]);
			if (t_op[k] == "H")
				check_count("o_if_valid latency", cyc, 1);
		end
		else if (t_op[k] == "W")
		begin
			access(WRITE, t_addr[k], t_wdata[k], got, cyc);
			// Exactly one beat on each write channel
			check_count("AW handshakes", aw_count - aw_before, 1);
			check_count("W handshakes", w_count - w_before, 1);
			check_value("o_awaddr", 32'(wr_addr), 32'(t_addr[k]));
			check_value("o_wdata", wr_data, t_wdata[k]);
		end
		else
		begin
			access(READ, t_addr[k], '0, got, cyc);
			check_value("o_dc_rdata", got, t_exp[k]);
			if (t_op[k] == "H")
				check_count("o_dc_done latency", cyc, 1);
		end
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================
	initial
	begin
		int k;
		int step;
		int err_before;
		int n_tests;
		int n_failed;
		clk          = 1'b0;
		i_arst_n     = 1'b0;
		i_if_req     = 1'b0;
		i_if_addr    = '0;
		i_dc_req     = 1'b0;
		i_dc_action  = READ;
		i_dc_addr    = '0;
		i_dc_wdata   = '0;
		i_arready    = 1'b0;
		i_rvalid     = 1'b0;
		i_rlast      = 1'b0;
		i_rid        = '0;
		i_rdata      = '0;
		i_awready    = 1'b0;
		i_wready     = 1'b0;
		i_bvalid     = 1'b0;
		rd_pending   = 1'b0;
		aw_seen      = 1'b0;
		w_seen       = 1'b0;
		aw_count     = 0;
		w_count      = 0;
		ar_count[0]  = 0;
		ar_count[1]  = 0;
		errors       = 0;
		n_ops        = 0;
		n_tests      = 0;
		n_failed     = 0;
		trace_loaded = 1'b0;
		load_trace();
		trace_loaded = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		i_arst_n = 1'b1;
		@(negedge clk);
		k = 0;
		while (k < n_ops)
		begin
			err_before = errors;
			run_op(k, step);
			n_tests++;
			if (errors != err_before)
				n_failed++;
			$display("op %0d %s %s %h: %s", k, t_port[k], t_op[k], t_addr[k],
				(errors == err_before) ? "ok" : "failed");
			k += step;
		end
		// Assertion failures from the bound checker
		errors += int'(dut.u_chk.assert_fails);
		$display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Run length scales with the trace
	initial
	begin
		wait (trace_loaded);
		repeat ((n_ops + 1) * CYCLES_PER_OP) @(posedge clk);
		$display("Watchdog expired with the trace still running at t=%0t", $time);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+logic
logic/axi_pkg.sv
logic/cache_pkg.sv
logic/i_cache.sv
logic/d_cache.sv
logic/memory_arbiter.sv
logic/mem_subsys_top.sv
sim/mem_subsys_chk.sv
sim/mem_subsys_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
	-f files.f \
	--top-module mem_subsys_tb \
	--Mdir obj_dir \
	-o mem_subsys_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/mem_subsys_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^All tests passed$" sim.log; then
	exit 0
fi
exit 1

//--- sim/mem_trace.txt
# port (I fetch, D load/store)  op (R read, H read that must hit, W write, P fetch paired with next line)
# address  write data  expected read data, all in hex
I R 00000100 00000000 A5000040
I H 00000108 00000000 A5000042
D R 00000200 00000000 A5000080
D H 0000020C 00000000 A5000083
D W 00000204 12345678 00000000
D H 00000204 00000000 12345678
D W 00000304 CAFEF00D 00000000
D R 00000304 00000000 CAFEF00D
D R 00000310 00000000 A50000C4
D R 00001310 00000000 A50004C4
D R 00000310 00000000 A50000C4
D R 00001314 00000000 A50004C5
I P 00000800 00000000 A5000200
D R 00000C40 00000000 A5000310
I P 00000A04 00000000 A5000281
D R 00000A04 00000000 A5000281
I R 00001100 00000000 A5000440
I R 00000104 00000000 A5000041
I H 0000010C 00000000 A5000043
D W 00000C44 0BADBEEF 00000000
D H 00000C44 00000000 0BADBEEF
D H 00000C48 00000000 A5000312
